// ==== rtl/lrelu_pkg.sv ====
`default_nettype none

package lrelu_pkg;

  localparam int UNITS          = 8;
  localparam int GROUPS         = 2;
  localparam int COEF_DEPTH     = 4;

  localparam int WORD_WIDTH_IN  = 16;
  localparam int WORD_WIDTH_OUT = 8;
  localparam int COEF_WIDTH     = 16;  // q8.8
  localparam int ACC_WIDTH      = 32;

  localparam int USER_WIDTH     = 2;
  localparam int I_USER_LRELU   = 0;
  localparam int I_USER_TAG     = 1;

  localparam int FRAC_BITS      = 8;
  localparam int LEAK_SLOPE     = 26;  // ~0.1 in q0.8
  localparam int LEAK_FRAC_BITS = 8;
  localparam int OUT_SHIFT      = 4;
  localparam int B_RESET        = 256; // 1.0

  typedef logic signed [WORD_WIDTH_IN-1:0]  in_lane_t;
  typedef logic signed [ACC_WIDTH-1:0]      acc_lane_t;
  typedef logic signed [WORD_WIDTH_OUT-1:0] out_lane_t;
  typedef logic signed [COEF_WIDTH-1:0]     coef_t;

  // group major, lane 0 of group 0 in the low bits
  typedef in_lane_t  [GROUPS-1:0][UNITS-1:0] in_vec_t;
  typedef acc_lane_t [GROUPS-1:0][UNITS-1:0] acc_vec_t;
  typedef out_lane_t [GROUPS-1:0][UNITS-1:0] out_vec_t;

  typedef coef_t [GROUPS-1:0] coef_vec_t;

  // order of the config walk
  typedef enum logic [1:0] {
    TGT_D = 2'd0,
    TGT_A = 2'd1,
    TGT_B = 2'd2
  } cfg_target_e;

endpackage

`default_nettype wire

// ==== rtl/stage_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface stage_if
  import lrelu_pkg::*;
#(
  parameter type data_t = acc_vec_t
);

  logic  valid;
  data_t data;
  logic  lrelu;  // apply leak slope in stage 2
  logic  tag;    // carried to m_user untouched

  modport src (output valid, data, lrelu, tag);
  modport dst (input  valid, data, lrelu, tag);

endinterface

`default_nettype wire

// ==== rtl/cfg_wr_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface cfg_wr_if
  import lrelu_pkg::*;
#(
  parameter int COEF_DEPTH = lrelu_pkg::COEF_DEPTH
);

  localparam int ADDR_WIDTH = (COEF_DEPTH > 1) ? $clog2(COEF_DEPTH) : 1;

  logic                  wr;
  cfg_target_e           target;
  logic [ADDR_WIDTH-1:0] addr;
  coef_vec_t             data;

  modport src (output wr, target, addr, data);
  modport dst (input  wr, target, addr, data);

endinterface

`default_nettype wire

// ==== rtl/config_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module config_loader
  import lrelu_pkg::*;
#(
  parameter int COEF_DEPTH = lrelu_pkg::COEF_DEPTH
)(
  input  logic      clk,
  input  logic      reset,
  input  logic      config_valid,
  input  logic      config_restart,
  input  coef_vec_t config_data,
  cfg_wr_if.src     cfg_wr
);

  localparam int ADDR_WIDTH = (COEF_DEPTH > 1) ? $clog2(COEF_DEPTH) : 1;
  localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(COEF_DEPTH - 1);

  cfg_target_e           state, state_next, cur_target;
  logic [ADDR_WIDTH-1:0] addr, addr_next, cur_addr;

  // a restart coinciding with a strobe turns that beat into the D write
  assign cur_target = config_restart ? TGT_D : state;
  assign cur_addr   = config_restart ? '0 : addr;

  always_comb begin
    state_next = cur_target;
    addr_next  = '0;
    case (cur_target)
      TGT_D: state_next = TGT_A;
      TGT_A: begin
        if (cur_addr == LAST_ADDR)
          state_next = TGT_B;
        else
          addr_next = cur_addr + 1'b1;
      end
      TGT_B: begin
        if (cur_addr == LAST_ADDR)
          state_next = TGT_D;  // wrap to the next load
        else
          addr_next = cur_addr + 1'b1;
      end
      default: state_next = TGT_D;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= TGT_D;
      addr      <= '0;
      cfg_wr.wr <= 1'b0;
    end else begin
      cfg_wr.wr <= config_valid;
      if (config_valid) begin
        state <= state_next;
        addr  <= addr_next;
      end else if (config_restart) begin
        state <= TGT_D;
        addr  <= '0;
      end
    end
  end

  // write payload, one cycle behind the strobe
  always_ff @(posedge clk) begin
    if (config_valid) begin
      cfg_wr.target <= cur_target;
      cfg_wr.addr   <= cur_addr;
      cfg_wr.data   <= config_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/coef_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module coef_bank
  import lrelu_pkg::*;
#(
  parameter int COEF_DEPTH = lrelu_pkg::COEF_DEPTH
)(
  input  logic      clk,
  input  logic      reset,
  cfg_wr_if.dst     cfg_wr,
  input  logic      config_restart,
  input  logic      s_valid,
  output coef_vec_t a_coef,
  output coef_vec_t b_coef,
  output coef_vec_t d_coef
);

  localparam int ADDR_WIDTH = (COEF_DEPTH > 1) ? $clog2(COEF_DEPTH) : 1;
  localparam logic [ADDR_WIDTH-1:0] LAST_IDX = ADDR_WIDTH'(COEF_DEPTH - 1);

  coef_vec_t             a_mem [COEF_DEPTH];
  coef_vec_t             b_mem [COEF_DEPTH];
  coef_vec_t             d_reg;
  logic [ADDR_WIDTH-1:0] rd_idx;

  always_ff @(posedge clk) begin
    if (reset) begin
      d_reg <= '0;
      for (int i = 0; i < COEF_DEPTH; i++) begin
        a_mem[i] <= '0;
        b_mem[i] <= {GROUPS{coef_t'(B_RESET)}};  // unity gain
      end
    end else if (cfg_wr.wr) begin
      case (cfg_wr.target)
        TGT_D:   d_reg <= cfg_wr.data;
        TGT_A:   a_mem[cfg_wr.addr] <= cfg_wr.data;
        TGT_B:   b_mem[cfg_wr.addr] <= cfg_wr.data;
        default: d_reg <= d_reg;
      endcase
    end
  end

  // channel index, one step per accepted beat
  always_ff @(posedge clk) begin
    if (reset || config_restart)
      rd_idx <= '0;
    else if (s_valid)
      rd_idx <= (rd_idx == LAST_IDX) ? '0 : rd_idx + 1'b1;
  end

  // read is combinational, the beat samples it in its input cycle
  assign a_coef = a_mem[rd_idx];
  assign b_coef = b_mem[rd_idx];
  assign d_coef = d_reg;

endmodule

`default_nettype wire

// ==== rtl/scale_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module scale_stage
  import lrelu_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  coef_vec_t a_coef,
  input  coef_vec_t b_coef,
  stage_if.dst      in_beat,
  stage_if.src      scaled_beat
);

  acc_vec_t scaled_next;

  // x*b in q8.8, drop the fraction, then offset
  function automatic acc_lane_t scale_lane(
    input in_lane_t x,
    input coef_t    a,
    input coef_t    b
  );
    acc_lane_t prod;
    prod = x * b;
    return (prod >>> FRAC_BITS) + acc_lane_t'(a);
  endfunction

  always_comb begin
    for (int g = 0; g < GROUPS; g++) begin
      for (int u = 0; u < UNITS; u++) begin
        scaled_next[g][u] = scale_lane(in_beat.data[g][u], a_coef[g], b_coef[g]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      scaled_beat.valid <= 1'b0;
    else
      scaled_beat.valid <= in_beat.valid;
  end

  always_ff @(posedge clk) begin
    if (in_beat.valid) begin
      scaled_beat.data  <= scaled_next;
      scaled_beat.lrelu <= in_beat.lrelu;
      scaled_beat.tag   <= in_beat.tag;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/leaky_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module leaky_stage
  import lrelu_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  coef_vec_t d_coef,
  stage_if.dst      scaled_beat,
  stage_if.src      biased_beat
);

  acc_vec_t biased_next;

  function automatic acc_lane_t leak_lane(
    input acc_lane_t s1,
    input logic      lrelu,
    input coef_t     d
  );
    acc_lane_t leaked;
    leaked = s1;
    if (lrelu && (s1 < 0))
      leaked = (s1 * LEAK_SLOPE) >>> LEAK_FRAC_BITS;  // floor, stays negative
    return leaked + acc_lane_t'(d);
  endfunction

  always_comb begin
    for (int g = 0; g < GROUPS; g++) begin
      for (int u = 0; u < UNITS; u++) begin
        biased_next[g][u] = leak_lane(scaled_beat.data[g][u], scaled_beat.lrelu, d_coef[g]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      biased_beat.valid <= 1'b0;
    else
      biased_beat.valid <= scaled_beat.valid;
  end

  always_ff @(posedge clk) begin
    if (scaled_beat.valid) begin
      biased_beat.data  <= biased_next;
      biased_beat.lrelu <= scaled_beat.lrelu;
      biased_beat.tag   <= scaled_beat.tag;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/requant_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module requant_stage
  import lrelu_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  stage_if.dst                  biased_beat,
  output logic                  m_valid,
  output logic [USER_WIDTH-1:0] m_user,
  output out_vec_t              m_data
);

  localparam acc_lane_t SAT_MAX = acc_lane_t'((1 <<< (WORD_WIDTH_OUT - 1)) - 1);
  localparam acc_lane_t SAT_MIN = -SAT_MAX - 1;

  out_vec_t out_next;

  function automatic out_lane_t sat_lane(input acc_lane_t s2);
    acc_lane_t shifted;
    shifted = s2 >>> OUT_SHIFT;
    if (shifted > SAT_MAX)
      return out_lane_t'(SAT_MAX);
    else if (shifted < SAT_MIN)
      return out_lane_t'(SAT_MIN);
    return out_lane_t'(shifted);
  endfunction

  always_comb begin
    for (int g = 0; g < GROUPS; g++) begin
      for (int u = 0; u < UNITS; u++) begin
        out_next[g][u] = sat_lane(biased_beat.data[g][u]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      m_valid <= 1'b0;
    else
      m_valid <= biased_beat.valid;
  end

  always_ff @(posedge clk) begin
    if (biased_beat.valid) begin
      m_data               <= out_next;
      m_user[I_USER_LRELU] <= biased_beat.lrelu;
      m_user[I_USER_TAG]   <= biased_beat.tag;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/lrelu_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module lrelu_engine
  import lrelu_pkg::*;
#(
  parameter int UNITS      = lrelu_pkg::UNITS,
  parameter int GROUPS     = lrelu_pkg::GROUPS,
  parameter int COEF_DEPTH = lrelu_pkg::COEF_DEPTH
)(
  input  logic                                    clk,
  input  logic                                    reset,

  input  logic                                    s_valid,
  input  logic [USER_WIDTH-1:0]                   s_user,
  input  logic [GROUPS*UNITS*WORD_WIDTH_IN-1:0]   s_data,

  output logic                                    m_valid,
  output logic [USER_WIDTH-1:0]                   m_user,
  output logic [GROUPS*UNITS*WORD_WIDTH_OUT-1:0]  m_data,

  input  logic                                    config_valid,
  input  logic [GROUPS*COEF_WIDTH-1:0]            config_data,  // one word per group
  input  logic                                    config_restart
);

  coef_vec_t a_coef, b_coef, d_coef;

  stage_if #(.data_t(in_vec_t))  in_beat ();
  stage_if #(.data_t(acc_vec_t)) scaled_beat ();
  stage_if #(.data_t(acc_vec_t)) biased_beat ();

  cfg_wr_if #(.COEF_DEPTH(COEF_DEPTH)) cfg_wr ();

  assign in_beat.valid = s_valid;
  assign in_beat.data  = s_data;
  assign in_beat.lrelu = s_user[I_USER_LRELU];
  assign in_beat.tag   = s_user[I_USER_TAG];

  config_loader #(
    .COEF_DEPTH     (COEF_DEPTH)
  ) u_config_loader (
    .clk            (clk),
    .reset          (reset),
    .config_valid   (config_valid),
    .config_restart (config_restart),
    .config_data    (config_data),
    .cfg_wr         (cfg_wr)
  );

  coef_bank #(
    .COEF_DEPTH     (COEF_DEPTH)
  ) u_coef_bank (
    .clk            (clk),
    .reset          (reset),
    .cfg_wr         (cfg_wr),
    .config_restart (config_restart),
    .s_valid        (s_valid),
    .a_coef         (a_coef),
    .b_coef         (b_coef),
    .d_coef         (d_coef)
  );

  scale_stage u_scale_stage (
    .clk         (clk),
    .reset       (reset),
    .a_coef      (a_coef),
    .b_coef      (b_coef),
    .in_beat     (in_beat),
    .scaled_beat (scaled_beat)
  );

  leaky_stage u_leaky_stage (
    .clk         (clk),
    .reset       (reset),
    .d_coef      (d_coef),
    .scaled_beat (scaled_beat),
    .biased_beat (biased_beat)
  );

  requant_stage u_requant_stage (
    .clk         (clk),
    .reset       (reset),
    .biased_beat (biased_beat),
    .m_valid     (m_valid),
    .m_user      (m_user),
    .m_data      (m_data)
  );

endmodule

`default_nettype wire

// ==== verif/tb_lrelu_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_lrelu_engine
  import lrelu_pkg::*;
();

  localparam int S_BITS      = GROUPS * UNITS * WORD_WIDTH_IN;
  localparam int M_BITS      = GROUPS * UNITS * WORD_WIDTH_OUT;
  localparam int C_BITS      = GROUPS * COEF_WIDTH;
  localparam int LATENCY     = 3;
  localparam int CFG_BEATS   = 2 * COEF_DEPTH + 1;  // d, then a words, then b words
  localparam int DRAIN_LIMIT = 50;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  s_valid;
  logic [USER_WIDTH-1:0] s_user;
  logic [S_BITS-1:0]     s_data;
  logic                  m_valid;
  logic [USER_WIDTH-1:0] m_user;
  logic [M_BITS-1:0]     m_data;
  logic                  config_valid;
  logic [C_BITS-1:0]     config_data;
  logic                  config_restart;

  coef_t a_model [COEF_DEPTH][GROUPS];
  coef_t b_model [COEF_DEPTH][GROUPS];
  coef_t d_model [GROUPS];
  int    cfg_step;
  int    chan_idx;

  logic [M_BITS-1:0]     exp_data_q [$];
  logic [USER_WIDTH-1:0] exp_user_q [$];
  int                    exp_due_q  [$];

  logic [31:0] lfsr_state;
  int          cycle_count     = 0;
  int          value_errors    = 0;
  int          protocol_errors = 0;
  int          beats_checked   = 0;
  logic        timed_out       = 1'b0;

  lrelu_engine #(
    .UNITS          (UNITS),
    .GROUPS         (GROUPS),
    .COEF_DEPTH     (COEF_DEPTH)
  ) u_lrelu_engine (
    .clk            (clk),
    .reset          (reset),
    .s_valid        (s_valid),
    .s_user         (s_user),
    .s_data         (s_data),
    .m_valid        (m_valid),
    .m_user         (m_user),
    .m_data         (m_data),
    .config_valid   (config_valid),
    .config_data    (config_data),
    .config_restart (config_restart)
  );

  always #20 clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 1;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  function automatic logic random_flag();
    logic [31:0] r;
    r = random_bits(1);
    return r[0];
  endfunction

  // kind 0 small a/d, 1 signed b, 2 large b, 3 positive b
  function automatic coef_t random_coef(input int kind);
    logic [31:0] r;
    r = random_bits(14);
    case (kind)
      1:       return coef_t'({{5{r[10]}}, r[10:0]});  // -4.0 .. 4.0
      2:       return coef_t'({2'b01, r[13:0]});       // 64.0 .. 127.99
      3:       return coef_t'({6'b0, r[9:0]});
      default: return coef_t'({{4{r[11]}}, r[11:0]});
    endcase
  endfunction

  function automatic logic [S_BITS-1:0] random_beat(input int mode);
    logic [S_BITS-1:0] beat;
    logic [31:0]       r;
    for (int i = 0; i < GROUPS * UNITS; i++) begin
      r = random_bits(16);
      if (mode == 1 && random_bits(3) != 0)
        r[15] = 1'b1;  // mostly negative
      else if (mode == 2)
        r[14] = ~r[15];  // large magnitude of either sign
      beat[i*WORD_WIDTH_IN +: WORD_WIDTH_IN] = r[15:0];
    end
    return beat;
  endfunction

  function automatic out_lane_t expected_lane(input in_lane_t x, input coef_t a,
                                              input coef_t b, input coef_t d,
                                              input logic lrelu);
    longint s1, s2, q;
    s1 = ((longint'(x) * longint'(b)) >>> FRAC_BITS) + longint'(a);
    s2 = (lrelu && s1 < 0) ? ((s1 * LEAK_SLOPE) >>> 8) : s1;
    q  = (s2 + longint'(d)) >>> OUT_SHIFT;
    if (q > 127)
      q = 127;
    else if (q < -128)
      q = -128;
    return out_lane_t'(q);
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      s_valid        <= 1'b0;
      config_valid   <= 1'b0;
      config_restart <= 1'b0;
    end
  endtask

  task automatic send_beat(input logic [USER_WIDTH-1:0] user, input logic [S_BITS-1:0] data);
    logic [M_BITS-1:0] want;
    int                lane;
    for (int g = 0; g < GROUPS; g++) begin
      for (int u = 0; u < UNITS; u++) begin
        lane = g * UNITS + u;
        want[lane*WORD_WIDTH_OUT +: WORD_WIDTH_OUT] = expected_lane(
          data[lane*WORD_WIDTH_IN +: WORD_WIDTH_IN], a_model[chan_idx][g],
          b_model[chan_idx][g], d_model[g], user[I_USER_LRELU]);
      end
    end
    chan_idx = (chan_idx + 1) % COEF_DEPTH;
    @(posedge clk);
    s_valid        <= 1'b1;
    config_valid   <= 1'b0;
    config_restart <= 1'b0;
    s_user         <= user;
    s_data         <= data;
    exp_data_q.push_back(want);
    exp_user_q.push_back(user);
    exp_due_q.push_back(cycle_count + LATENCY + 1);  // this edge not counted yet
  endtask

  // flag 0 clear, 1 set, 2 random
  task automatic send_random_beats(input int count, input int mode, input int flag,
                                   input int gap_bits);
    logic [USER_WIDTH-1:0] user;
    for (int i = 0; i < count; i++) begin
      user[I_USER_TAG]   = random_flag();
      user[I_USER_LRELU] = (flag == 2) ? random_flag() : flag[0];
      send_beat(user, random_beat(mode));
      if (gap_bits > 0)
        idle_cycles(random_bits(gap_bits));
    end
    idle_cycles(1);
  endtask

  task automatic send_config(input logic restart, input int b_kind);
    logic [C_BITS-1:0] data;
    if (restart) begin
      cfg_step = 0;
      chan_idx = 0;
    end
    for (int g = 0; g < GROUPS; g++) begin
      data[g*COEF_WIDTH +: COEF_WIDTH] = random_coef(cfg_step > COEF_DEPTH ? b_kind : 0);
      if (cfg_step == 0)
        d_model[g] = data[g*COEF_WIDTH +: COEF_WIDTH];
      else if (cfg_step <= COEF_DEPTH)
        a_model[cfg_step-1][g] = data[g*COEF_WIDTH +: COEF_WIDTH];
      else
        b_model[cfg_step-COEF_DEPTH-1][g] = data[g*COEF_WIDTH +: COEF_WIDTH];
    end
    cfg_step = (cfg_step + 1) % CFG_BEATS;
    @(posedge clk);
    s_valid        <= 1'b0;
    config_valid   <= 1'b1;
    config_restart <= restart;
    config_data    <= data;
  endtask

  task automatic load_config(input int beats, input int b_kind, input logic restart_first);
    for (int i = 0; i < beats; i++)
      send_config(restart_first && i == 0, b_kind);
    idle_cycles(4);  // let the writes land before new beats
  endtask

  task automatic restart_loader();
    cfg_step = 0;
    chan_idx = 0;
    @(posedge clk);
    config_valid   <= 1'b0;
    config_restart <= 1'b1;
    idle_cycles(2);
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    while (exp_due_q.size() > 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_due_q.size() > 0) begin
      $display("timed out after %0d cycles, %0d beats never came out", waited,
               exp_due_q.size());
      timed_out = 1'b1;
    end
    idle_cycles(2);
  endtask

  task automatic check_output();
    logic [M_BITS-1:0]     want;
    logic [USER_WIDTH-1:0] want_user;
    out_lane_t             want_lane, got_lane;
    int                    lane;
    want      = exp_data_q.pop_front();
    want_user = exp_user_q.pop_front();
    void'(exp_due_q.pop_front());
    if (!m_valid) begin
      $display("m_valid stayed low at %0t where a beat was due", $time);
      protocol_errors++;
    end else begin
      beats_checked++;
      if (m_user !== want_user) begin
        $display("FAILED at %0t: m_user expected %b, got %b", $time, want_user, m_user);
        value_errors++;
      end
      for (int g = 0; g < GROUPS; g++) begin
        for (int u = 0; u < UNITS; u++) begin
          lane      = g * UNITS + u;
          want_lane = want[lane*WORD_WIDTH_OUT +: WORD_WIDTH_OUT];
          got_lane  = m_data[lane*WORD_WIDTH_OUT +: WORD_WIDTH_OUT];
          if (got_lane !== want_lane) begin
            $display("FAILED at %0t: m_data[%0d][%0d] expected %0d, got %0d", $time, g, u,
                     want_lane, got_lane);
            value_errors++;
          end
        end
      end
    end
  endtask

  // outputs settle by the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      if (exp_due_q.size() > 0 && exp_due_q[0] == cycle_count)
        check_output();
      else if (m_valid) begin
        $display("m_valid went high at %0t with no beat expected", $time);
        protocol_errors++;
      end
    end
  end

  initial begin
    lfsr_state     = 32'hb290;
    reset          = 1'b1;
    s_valid        = 1'b0;
    s_user         = '0;
    s_data         = '0;
    config_valid   = 1'b0;
    config_data    = '0;
    config_restart = 1'b0;
    cfg_step       = 0;
    chan_idx       = 0;
    for (int g = 0; g < GROUPS; g++) begin
      d_model[g] = '0;
      for (int i = 0; i < COEF_DEPTH; i++) begin
        a_model[i][g] = '0;
        b_model[i][g] = coef_t'(B_RESET);
      end
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    idle_cycles(6);  // no m_valid before the first beat

    send_random_beats(12, 0, 0, 2);  // defaults with random gaps
    drain_outputs();
    if (!timed_out) begin
      load_config(CFG_BEATS, 1, 1'b0);
      send_random_beats(4 * COEF_DEPTH + 3, 0, 2, 0);
      drain_outputs();
    end
    if (!timed_out) begin
      load_config(CFG_BEATS, 3, 1'b0);
      send_random_beats(3 * COEF_DEPTH, 1, 1, 1);  // leaky path
      drain_outputs();
    end
    if (!timed_out) begin
      load_config(CFG_BEATS, 2, 1'b0);
      send_random_beats(3 * COEF_DEPTH, 2, 2, 0);  // saturation
      drain_outputs();
    end
    if (!timed_out) begin
      send_random_beats(3, 0, 2, 0);  // channel index left mid cycle
      drain_outputs();
      load_config(3, 1, 1'b0);
      restart_loader();
      load_config(CFG_BEATS, 3, 1'b0);
      send_random_beats(2 * COEF_DEPTH + 1, 0, 2, 1);
      drain_outputs();
    end
    if (!timed_out) begin
      load_config(3, 1, 1'b0);
      load_config(CFG_BEATS, 3, 1'b1);  // restart on the d beat itself
      send_random_beats(2 * COEF_DEPTH + 1, 0, 2, 1);
      drain_outputs();
    end

    $display("summary: %0d beats checked, %0d value errors, %0d protocol errors, timeout %0d",
             beats_checked, value_errors, protocol_errors, timed_out);
    if (value_errors == 0 && protocol_errors == 0 && !timed_out)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/lrelu_pkg.sv
rtl/stage_if.sv
rtl/cfg_wr_if.sv
rtl/config_loader.sv
rtl/coef_bank.sv
rtl/scale_stage.sv
rtl/leaky_stage.sv
rtl/requant_stage.sv
rtl/lrelu_engine.sv
verif/tb_lrelu_engine.sv

// ==== Makefile ====
TOP := tb_lrelu_engine

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
